// ==== build.f ====
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_control.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_pc_unit.sv
rtl/rv_wb_master.sv
rtl/rv_core_top.sv
verification/rv_wb_mem_model.sv
verification/rv_tb.sv

// ==== Bender.yml ====
package:
  name: rv64_core

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_pkg.sv
      - rtl/rv_control.sv
      - rtl/rv_regfile.sv
      - rtl/rv_alu.sv
      - rtl/rv_pc_unit.sv
      - rtl/rv_wb_master.sv
      - rtl/rv_core_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/rv_wb_mem_model.sv
      - verification/rv_tb.sv

// ==== verification/rv_tb.sv ====
// rv64 core testbench
`include "rv_consts.svh"
`default_nettype none

module rv_tb import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // one expected store on the bus
  typedef struct packed {
    logic [63:0] addr;
    logic [7:0]  sel;
    logic [63:0] dat;
  } store_s;

  logic                clk;
  logic                rst_n;
  wb_m2s_s             wb_m2s;
  logic [`RV_XLEN-1:0] wb_dat_i;
  logic                wb_ack_i;
  logic                halt;
  logic                illegal;

  store_s              exp_q[$];
  logic [63:0]         place_addr;
  int                  errors = 0;
  int                  timeouts = 0;
  int                  stores_checked = 0;
  bit                  ok;

  rv_core_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_m2s   (wb_m2s),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i),
    .halt     (halt),
    .illegal  (illegal)
  );

  rv_wb_mem_model u_mem (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_m2s (wb_m2s),
    .dat_r  (wb_dat_i),
    .ack    (wb_ack_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_fail(input string msg);
    errors++;
    $display("[FAIL] %0d ns: %s", $time, msg);
  endtask

  // bus protocol and status
  assert property (@(posedge clk) !rst_n |-> !wb_m2s.cyc && !wb_m2s.stb && !halt && !illegal)
    else report_fail("bus or status active during reset");
  assert property (@(posedge clk) disable iff (!rst_n) wb_m2s.stb == wb_m2s.cyc)
    else report_fail("cyc and stb differ");
  // payload held until ack
  assert property (@(posedge clk) disable iff (!rst_n)
    (wb_m2s.stb && !wb_ack_i) |=> $stable(wb_m2s.adr) && $stable(wb_m2s.we) &&
                                   $stable(wb_m2s.sel) && $stable(wb_m2s.dat))
    else report_fail("bus payload changed before ack");
  assert property (@(posedge clk) disable iff (!rst_n) (wb_m2s.cyc && wb_ack_i) |=> !wb_m2s.cyc)
    else report_fail("cyc still high after ack");
  // every fetch and data address of the test programs is word aligned
  assert property (@(posedge clk) disable iff (!rst_n) wb_m2s.cyc |-> wb_m2s.adr[1:0] == 2'b00)
    else report_fail("bus address not word aligned");
  // stopped core stays off the bus
  assert property (@(posedge clk) disable iff (!rst_n) (halt || illegal) |-> !wb_m2s.cyc)
    else report_fail("bus cycle after halt or illegal");
  assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
    else report_fail("halt dropped before reset");
  assert property (@(posedge clk) disable iff (!rst_n) illegal |=> illegal)
    else report_fail("illegal dropped before reset");

  // instruction encoders
  function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    enc_r = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OP_OP};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                        input int rd, input logic [6:0] op);
    enc_i = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                        input int f3);
    enc_s = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] op);
    enc_u = {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_j(input int imm, input int rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OP_JAL};
  endfunction

  function automatic logic [63:0] lane_mask(input logic [7:0] sel);
    for (int b = 0; b < 8; b++) begin
      lane_mask[8*b +: 8] = {8{sel[b]}};
    end
  endfunction

  task automatic place_inst(input logic [31:0] inst);
    u_mem.put_inst(place_addr, inst);
    place_addr = place_addr + 64'd4;
  endtask

  task automatic expect_store(input logic [63:0] addr, input logic [7:0] sel,
                              input logic [63:0] dat);
    store_s s;
    s.addr = addr;
    s.sel  = sel;
    s.dat  = dat;
    exp_q.push_back(s);
  endtask

  // sd of rs2 to off(x10) carrying a known value
  task automatic place_checked_sd(input int rs2, input int off, input logic [63:0] value);
    place_inst(enc_s(off, rs2, 10, `RV_F3_D));
    expect_store(64'h2000 + 64'(off), 8'hff, value);
  endtask

  task automatic load_program(input int prog);
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] w;
    logic [63:0] here;
    u_mem.clear_mem();
    exp_q.delete();
    place_addr = `RV_RESET_PC;
    // x10 holds the data base 0x2000 for every store
    place_inst(enc_u(2, 10, `RV_OP_LUI));
    if (prog == 1) begin
      a = 64'd100;
      b = -64'sd7;
      w = 32'h8765_4321;
      // load source with the test word in the upper lane
      u_mem.put_dword(64'h2100, {w, 32'h0bad_f00d});
      place_inst(enc_i(100, 0, `RV_F3_ADD, 1, `RV_OP_IMM));
      place_inst(enc_i(-7, 0, `RV_F3_ADD, 2, `RV_OP_IMM));
      place_inst(enc_r(`RV_F7_BASE, 2, 1, `RV_F3_ADD, 3));
      place_checked_sd(3, 0, a + b);
      place_inst(enc_r(`RV_F7_SUB, 1, 2, `RV_F3_ADD, 4));
      place_checked_sd(4, 8, b - a);
      place_inst(enc_r(`RV_F7_BASE, 2, 1, `RV_F3_AND, 5));
      place_checked_sd(5, 16, a & b);
      place_inst(enc_r(`RV_F7_BASE, 2, 1, `RV_F3_OR, 6));
      place_checked_sd(6, 24, a | b);
      place_inst(enc_r(`RV_F7_BASE, 2, 1, `RV_F3_XOR, 7));
      place_checked_sd(7, 32, a ^ b);
      // slt in both directions
      place_inst(enc_r(`RV_F7_BASE, 1, 2, `RV_F3_SLT, 8));
      place_inst(enc_r(`RV_F7_BASE, 2, 1, `RV_F3_SLT, 9));
      place_checked_sd(8, 40, ($signed(b) < $signed(a)) ? 64'd1 : 64'd0);
      place_checked_sd(9, 48, ($signed(a) < $signed(b)) ? 64'd1 : 64'd0);
      // lui with bit 31 set sign-extends to 64 bits
      place_inst(enc_u(32'h80000, 11, `RV_OP_LUI));
      place_checked_sd(11, 56, {{32{1'b1}}, 32'h8000_0000});
      here = place_addr;
      place_inst(enc_u(1, 12, `RV_OP_AUIPC));
      place_checked_sd(12, 64, here + 64'h1000);
      // lw from the upper lane then sw and ld of one dword
      place_inst(enc_i(32'h104, 10, `RV_F3_W, 13, `RV_OP_LOAD));
      place_checked_sd(13, 80, {{32{w[31]}}, w});
      place_inst(enc_s(76, 13, 10, `RV_F3_W));
      expect_store(64'h204c, 8'hf0, {w, 32'h0});
      place_inst(enc_i(72, 10, `RV_F3_D, 14, `RV_OP_LOAD));
      place_checked_sd(14, 88, {w, 32'h0});
      // jal over two stores
      here = place_addr;
      place_inst(enc_j(12, 15));
      place_inst(enc_s(96, 0, 10, `RV_F3_D));
      place_inst(enc_s(96, 0, 10, `RV_F3_D));
      place_checked_sd(15, 96, here + 64'd4);
      // jalr with an odd offset drops bit 0 of the target
      place_inst(enc_u(0, 16, `RV_OP_AUIPC));
      here = place_addr;
      place_inst(enc_i(17, 16, `RV_F3_ADD, 17, `RV_OP_JALR));
      place_inst(enc_s(104, 0, 10, `RV_F3_D));
      place_inst(enc_s(104, 0, 10, `RV_F3_D));
      place_checked_sd(17, 104, here + 64'd4);
      place_inst(`RV_EBREAK);
    end else begin
      place_inst(enc_i(32'h123, 0, `RV_F3_ADD, 1, `RV_OP_IMM));
      place_checked_sd(1, 0, 64'h123);
      // all-zero word is not a legal encoding
      place_inst(32'h0);
      place_inst(enc_s(8, 1, 10, `RV_F3_D));
    end
  endtask

  // compare one acked write with the head of the queue
  task automatic check_store();
    store_s      want;
    logic [63:0] mask;
    assert (exp_q.size() > 0)
      else report_fail($sformatf("unexpected store to %h", wb_m2s.adr));
    if (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      mask = lane_mask(want.sel);
      stores_checked++;
      assert (wb_m2s.adr == want.addr && wb_m2s.sel == want.sel)
        else report_fail($sformatf("store adr %h sel %h, expected adr %h sel %h",
                                   wb_m2s.adr, wb_m2s.sel, want.addr, want.sel));
      assert ((wb_m2s.dat & mask) == (want.dat & mask))
        else report_fail($sformatf("store to %h dat %h, expected %h",
                                   want.addr, wb_m2s.dat, want.dat));
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && wb_m2s.cyc && wb_m2s.stb && wb_m2s.we && wb_ack_i) begin
      check_store();
    end
  end

  // reset and program load followed by the first fetch
  task automatic start_run(input int prog, output bit ok);
    int cycles;
    rst_n = 1'b0;
    load_program(prog);
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    cycles = 0;
    while (!wb_m2s.cyc && cycles < 16) begin
      @(negedge clk);
      cycles++;
    end
    ok = wb_m2s.cyc;
    if (!ok) begin
      timeouts++;
      $display("timeout: no bus cycle within 16 cycles after reset release");
    end else begin
      assert (cycles == 1 && wb_m2s.adr == `RV_RESET_PC && !wb_m2s.we)
        else report_fail($sformatf("first fetch after %0d cycles at %h we %b",
                                   cycles, wb_m2s.adr, wb_m2s.we));
    end
  endtask

  task automatic wait_for_stop(output bit ok);
    int cycles;
    cycles = 0;
    while (!(halt || illegal) && cycles < 3000) begin
      @(negedge clk);
      cycles++;
    end
    ok = halt || illegal;
    if (!ok) begin
      timeouts++;
      $display("timeout: core neither halted nor flagged illegal within 3000 cycles");
    end
  endtask

  // idle window where the bus must stay quiet
  task automatic check_stop(input bit want_halt);
    repeat (20) @(negedge clk);
    assert (halt == want_halt && illegal == !want_halt)
      else report_fail($sformatf("halt %b illegal %b at stop", halt, illegal));
    assert (exp_q.size() == 0)
      else report_fail($sformatf("%0d expected stores never reached the bus", exp_q.size()));
    exp_q.delete();
  endtask

  initial begin
    rst_n = 1'b0;
    start_run(1, ok);
    if (ok) begin
      wait_for_stop(ok);
    end
    if (ok) begin
      check_stop(1'b1);
      start_run(2, ok);
    end
    if (ok) begin
      wait_for_stop(ok);
    end
    if (ok) begin
      check_stop(1'b0);
    end
    $display("stores checked: %0d, errors: %0d, timeouts: %0d",
             stores_checked, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/rv_wb_mem_model.sv ====
// wishbone memory model
`include "rv_consts.svh"
`default_nettype none

module rv_wb_mem_model import rv_pkg::*; (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire wb_m2s_s        wb_m2s,
  output logic [`RV_XLEN-1:0] dat_r,
  output logic                ack
);

  timeunit 1ns;
  timeprecision 1ps;

  // 16 KiB, covers program at 0x1000 and data at 0x2000
  localparam int WORDS = 2048;

  logic [`RV_XLEN-1:0] mem [WORDS];
  integer              seed = 20834;
  logic [1:0]          delay;
  logic [1:0]          wait_cnt;
  logic [10:0]         idx;

  assign idx = wb_m2s.adr[13:3];

  // slave side, driven on the falling edge
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack      <= 1'b0;
      dat_r    <= '0;
      wait_cnt <= '0;
      delay    <= 2'($random(seed) & 3);
    end else if (ack) begin
      // one ack per transfer, new wait count for the next one
      ack      <= 1'b0;
      wait_cnt <= '0;
      delay    <= 2'($random(seed) & 3);
    end else if (wb_m2s.cyc && wb_m2s.stb) begin
      if (wait_cnt == delay) begin
        ack   <= 1'b1;
        dat_r <= mem[idx];
        if (wb_m2s.we) begin
          // byte enables
          for (int b = 0; b < 8; b++) begin
            if (wb_m2s.sel[b]) begin
              mem[idx][8*b +: 8] = wb_m2s.dat[8*b +: 8];
            end
          end
        end
      end else begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

  task automatic clear_mem();
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = '0;
    end
  endtask

  task automatic put_dword(input logic [63:0] addr, input logic [63:0] data);
    mem[addr[13:3]] = data;
  endtask

  // instruction into the lane picked by addr bit 2
  task automatic put_inst(input logic [63:0] addr, input logic [31:0] inst);
    if (addr[2]) begin
      mem[addr[13:3]][63:32] = inst;
    end else begin
      mem[addr[13:3]][31:0] = inst;
    end
  endtask

endmodule

`default_nettype wire

// ==== rtl/rv_core_top.sv ====
// rv64 core top level
`include "rv_consts.svh"
`default_nettype none

module rv_core_top import rv_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst_n,
  output wb_m2s_s                  wb_m2s,
  input  wire logic [`RV_XLEN-1:0] wb_dat_i,
  input  wire logic                wb_ack_i,
  output logic                     halt,
  output logic                     illegal
);

  ctrl_s               ctrl;
  bus_req_s            bus_req;
  bus_rsp_s            bus_rsp;
  logic                rf_we;
  logic                pc_we;
  logic                inst_latch;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] rdata_1;
  logic [`RV_XLEN-1:0] rdata_2;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] inst_pc;
  logic [`RV_XLEN-1:0] pc_plus4;

  // decode and sequencing
  rv_control u_control (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus_rsp    (bus_rsp),
    .alu_result (alu_result),
    .rs2_data   (rdata_2),
    .pc         (pc),
    .ctrl       (ctrl),
    .bus_req    (bus_req),
    .rf_we      (rf_we),
    .pc_we      (pc_we),
    .inst_latch (inst_latch),
    .halt       (halt),
    .illegal    (illegal)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .rf_we      (rf_we),
    .alu_result (alu_result),
    .load_data  (bus_rsp.rdata),
    .pc_plus4   (pc_plus4),
    .rdata_1    (rdata_1),
    .rdata_2    (rdata_2)
  );

  rv_alu u_alu (
    .ctrl       (ctrl),
    .rdata_1    (rdata_1),
    .rdata_2    (rdata_2),
    .inst_pc    (inst_pc),
    .alu_result (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .pc_we      (pc_we),
    .inst_latch (inst_latch),
    .alu_result (alu_result),
    .pc         (pc),
    .inst_pc    (inst_pc),
    .pc_plus4   (pc_plus4)
  );

  // fetch, load and store share the one port
  rv_wb_master u_wb_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .wb_m2s   (wb_m2s),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i)
  );

endmodule

`default_nettype wire

// ==== rtl/rv_wb_master.sv ====
// wishbone classic bus master
`include "rv_consts.svh"
`default_nettype none

module rv_wb_master import rv_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire bus_req_s            bus_req,
  output bus_rsp_s                 bus_rsp,
  output wb_m2s_s                  wb_m2s,
  input  wire logic [`RV_XLEN-1:0] wb_dat_i,
  input  wire logic                wb_ack_i
);

  logic                cyc_q;
  logic                we_q;
  logic [7:0]          sel_q;
  logic [`RV_XLEN-1:0] adr_q;
  logic [`RV_XLEN-1:0] dat_q;
  mem_size_e           size_q;
  logic                signed_q;
  logic                start;
  logic [7:0]          sel_d;
  logic [`RV_XLEN-1:0] dat_d;
  logic [31:0]         word;

  // new cycle only from idle
  assign start = !cyc_q && bus_req.valid;

  // byte lanes, word half picked by addr bit 2
  always_comb begin
    if (bus_req.size == SIZE_DOUBLE) begin
      sel_d = 8'hff;
      dat_d = bus_req.wdata;
    end else if (bus_req.addr[2]) begin
      sel_d = 8'hf0;
      dat_d = {bus_req.wdata[31:0], 32'b0};
    end else begin
      sel_d = 8'h0f;
      dat_d = {32'b0, bus_req.wdata[31:0]};
    end
  end

  // cyc/stb: rise on start, drop after ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q <= 1'b0;
    end else if (cyc_q && wb_ack_i) begin
      cyc_q <= 1'b0;
    end else if (start) begin
      cyc_q <= 1'b1;
    end
  end

  // transfer payload, held until ack
  always_ff @(posedge clk) begin
    if (start) begin
      we_q     <= bus_req.we;
      sel_q    <= sel_d;
      adr_q    <= bus_req.addr;
      dat_q    <= dat_d;
      size_q   <= bus_req.size;
      signed_q <= bus_req.load_signed;
    end
  end

  always_comb begin
    wb_m2s.cyc = cyc_q;
    wb_m2s.stb = cyc_q;
    wb_m2s.we  = we_q;
    wb_m2s.sel = sel_q;
    wb_m2s.adr = adr_q;
    wb_m2s.dat = dat_q;
  end

  // read data lane for word access
  assign word = adr_q[2] ? wb_dat_i[63:32] : wb_dat_i[31:0];

  // response valid in the ack cycle only
  always_comb begin
    bus_rsp.done = cyc_q && wb_ack_i;
    if (size_q == SIZE_DOUBLE) begin
      bus_rsp.rdata = wb_dat_i;
    end else if (signed_q) begin
      bus_rsp.rdata = {{32{word[31]}}, word};
    end else begin
      bus_rsp.rdata = {32'b0, word};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rv_pc_unit.sv ====
// program counter unit
`include "rv_consts.svh"
`default_nettype none

module rv_pc_unit import rv_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire ctrl_s               ctrl,
  input  wire logic                pc_we,
  input  wire logic                inst_latch,
  input  wire logic [`RV_XLEN-1:0] alu_result,
  output logic      [`RV_XLEN-1:0] pc,
  output logic      [`RV_XLEN-1:0] inst_pc,
  output logic      [`RV_XLEN-1:0] pc_plus4
);

  logic [`RV_XLEN-1:0] next_pc;

  // link value for jal/jalr
  assign pc_plus4 = inst_pc + 64'd4;

  always_comb begin
    case (ctrl.pc_sel)
      PC_JAL:  next_pc = inst_pc + ctrl.imm;
      // jalr target has bit 0 cleared
      PC_JALR: next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
      default: next_pc = pc_plus4;
    endcase
  end

  // fetch pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else if (pc_we) begin
      pc <= next_pc;
    end
  end

  // pc of the instruction in flight, taken with the fetched word
  always_ff @(posedge clk) begin
    if (inst_latch) begin
      inst_pc <= pc;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rv_alu.sv ====
// integer alu
`include "rv_consts.svh"
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  wire ctrl_s               ctrl,
  input  wire logic [`RV_XLEN-1:0] rdata_1,
  input  wire logic [`RV_XLEN-1:0] rdata_2,
  input  wire logic [`RV_XLEN-1:0] inst_pc,
  output logic      [`RV_XLEN-1:0] alu_result
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic                lt;

  // operand a: register or pc of this instruction (auipc)
  assign op_a = (ctrl.op_a_sel == OP_A_PC) ? inst_pc : rdata_1;
  // operand b: register or immediate
  assign op_b = ctrl.use_imm ? ctrl.imm : rdata_2;

  // signed compare for slt
  assign lt = $signed(op_a) < $signed(op_b);

  always_comb begin
    case (ctrl.alu_op)
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_XOR: alu_result = op_a ^ op_b;
      ALU_SLT: alu_result = {{(`RV_XLEN-1){1'b0}}, lt};
      // add also forms addresses and jalr targets
      default: alu_result = op_a + op_b;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
// integer register file
`include "rv_consts.svh"
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire ctrl_s               ctrl,
  input  wire logic                rf_we,
  input  wire logic [`RV_XLEN-1:0] alu_result,
  input  wire logic [`RV_XLEN-1:0] load_data,
  input  wire logic [`RV_XLEN-1:0] pc_plus4,
  output logic      [`RV_XLEN-1:0] rdata_1,
  output logic      [`RV_XLEN-1:0] rdata_2
);

  logic [`RV_XLEN-1:0] regs [32];
  logic [`RV_XLEN-1:0] wdata;

  // write back source
  always_comb begin
    case (ctrl.wb_sel)
      WB_PC4:  wdata = pc_plus4;
      WB_LOAD: wdata = load_data;
      default: wdata = alu_result;
    endcase
  end

  // flop array, cleared on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we && ctrl.rd != 5'd0) begin
      regs[ctrl.rd] <= wdata;
    end
  end

  // x0 reads as zero regardless of contents
  assign rdata_1 = (ctrl.rs1 == 5'd0) ? '0 : regs[ctrl.rs1];
  assign rdata_2 = (ctrl.rs2 == 5'd0) ? '0 : regs[ctrl.rs2];

endmodule

`default_nettype wire

// ==== rtl/rv_control.sv ====
// decoder and instruction sequencer
`include "rv_consts.svh"
`default_nettype none

module rv_control import rv_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire bus_rsp_s            bus_rsp,
  input  wire logic [`RV_XLEN-1:0] alu_result,
  input  wire logic [`RV_XLEN-1:0] rs2_data,
  input  wire logic [`RV_XLEN-1:0] pc,
  output ctrl_s                    ctrl,
  output bus_req_s                 bus_req,
  output logic                     rf_we,
  output logic                     pc_we,
  output logic                     inst_latch,
  output logic                     halt,
  output logic                     illegal
);

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_STOP
  } state_e;

  state_e    state;
  rv_inst_u  ir;
  logic      legal;
  logic      is_ebreak;
  logic      is_load;
  logic      is_store;
  logic      is_mem;
  logic      exec_done;
  mem_size_e mem_size;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = ir.r_fmt.opcode;
  assign funct3 = ir.r_fmt.funct3;
  assign funct7 = ir.r_fmt.funct7;

  // decode
  always_comb begin
    ctrl          = '0;
    ctrl.rs1      = ir.r_fmt.rs1;
    ctrl.rs2      = ir.r_fmt.rs2;
    ctrl.rd       = ir.r_fmt.rd;
    ctrl.alu_op   = ALU_ADD;
    ctrl.op_a_sel = OP_A_REG;
    ctrl.wb_sel   = WB_ALU;
    ctrl.pc_sel   = PC_SEQ;
    legal         = 1'b1;
    is_ebreak     = 1'b0;
    is_load       = 1'b0;
    is_store      = 1'b0;
    mem_size      = SIZE_WORD;
    case (opcode)
      `RV_OP_OP: begin
        if (funct7 == `RV_F7_SUB && funct3 == `RV_F3_ADD) begin
          ctrl.alu_op = ALU_SUB;
        end else if (funct7 != `RV_F7_BASE) begin
          legal = 1'b0;
        end else begin
          case (funct3)
            `RV_F3_ADD: ctrl.alu_op = ALU_ADD;
            `RV_F3_AND: ctrl.alu_op = ALU_AND;
            `RV_F3_OR:  ctrl.alu_op = ALU_OR;
            `RV_F3_XOR: ctrl.alu_op = ALU_XOR;
            `RV_F3_SLT: ctrl.alu_op = ALU_SLT;
            default:    legal = 1'b0;
          endcase
        end
      end
      `RV_OP_IMM: begin
        // addi only
        ctrl.imm     = {{52{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
        ctrl.use_imm = 1'b1;
        legal        = (funct3 == `RV_F3_ADD);
      end
      `RV_OP_LUI: begin
        // x0 as operand a, so result is the immediate
        ctrl.rs1     = 5'd0;
        ctrl.imm     = {{32{ir.u_fmt.imm[19]}}, ir.u_fmt.imm, 12'b0};
        ctrl.use_imm = 1'b1;
      end
      `RV_OP_AUIPC: begin
        ctrl.imm      = {{32{ir.u_fmt.imm[19]}}, ir.u_fmt.imm, 12'b0};
        ctrl.use_imm  = 1'b1;
        ctrl.op_a_sel = OP_A_PC;
      end
      `RV_OP_JAL: begin
        // j imm field holds imm[20|10:1|11|19:12]
        ctrl.imm    = {{44{ir.j_fmt.imm[19]}}, ir.j_fmt.imm[7:0], ir.j_fmt.imm[8],
                       ir.j_fmt.imm[18:9], 1'b0};
        ctrl.wb_sel = WB_PC4;
        ctrl.pc_sel = PC_JAL;
      end
      `RV_OP_JALR: begin
        ctrl.imm     = {{52{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
        ctrl.use_imm = 1'b1;
        ctrl.wb_sel  = WB_PC4;
        ctrl.pc_sel  = PC_JALR;
        legal        = (funct3 == `RV_F3_ADD);
      end
      `RV_OP_LOAD: begin
        ctrl.imm     = {{52{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
        ctrl.use_imm = 1'b1;
        ctrl.wb_sel  = WB_LOAD;
        is_load      = 1'b1;
        mem_size     = (funct3 == `RV_F3_D) ? SIZE_DOUBLE : SIZE_WORD;
        legal        = (funct3 == `RV_F3_W) || (funct3 == `RV_F3_D);
      end
      `RV_OP_STORE: begin
        ctrl.imm     = {{52{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
        ctrl.use_imm = 1'b1;
        is_store     = 1'b1;
        mem_size     = (funct3 == `RV_F3_D) ? SIZE_DOUBLE : SIZE_WORD;
        legal        = (funct3 == `RV_F3_W) || (funct3 == `RV_F3_D);
      end
      `RV_OP_SYSTEM: begin
        is_ebreak = (ir == `RV_EBREAK);
        legal     = is_ebreak;
      end
      default: legal = 1'b0;
    endcase
  end

  assign is_mem    = is_load || is_store;
  // alu type ops retire in the exec cycle
  assign exec_done = (state == ST_EXEC) && legal && !is_ebreak && !is_mem;

  assign inst_latch = (state == ST_FETCH) && bus_rsp.done;
  assign rf_we      = exec_done || ((state == ST_MEM) && bus_rsp.done && is_load);
  assign pc_we      = exec_done || ((state == ST_MEM) && bus_rsp.done);

  // bus request per phase
  always_comb begin
    bus_req             = '0;
    bus_req.size        = SIZE_WORD;
    bus_req.addr        = pc;
    bus_req.wdata       = rs2_data;
    if (state == ST_FETCH) begin
      bus_req.valid = 1'b1;
    end else if (state == ST_MEM) begin
      bus_req.valid       = 1'b1;
      bus_req.we          = is_store;
      bus_req.size        = mem_size;
      bus_req.load_signed = is_load && (mem_size == SIZE_WORD);
      bus_req.addr        = alu_result;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_FETCH;
      halt    <= 1'b0;
      illegal <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: begin
          if (bus_rsp.done) begin
            state <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (is_ebreak) begin
            halt  <= 1'b1;
            state <= ST_STOP;
          end else if (!legal) begin
            illegal <= 1'b1;
            state   <= ST_STOP;
          end else if (is_mem) begin
            state <= ST_MEM;
          end else begin
            state <= ST_FETCH;
          end
        end
        ST_MEM: begin
          if (bus_rsp.done) begin
            state <= ST_FETCH;
          end
        end
        // parked until reset
        default: state <= ST_STOP;
      endcase
    end
  end

  // instruction register, low lane of the aligned fetch data
  always_ff @(posedge clk) begin
    if (inst_latch) begin
      ir <= bus_rsp.rdata[31:0];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rv_pkg.sv ====
// rv64 core types
`include "rv_consts.svh"
`default_nettype none

package rv_pkg;

  // instruction format views
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_s;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_s;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_s;

  // u and j share a layout, the bit order of imm differs
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uj_fmt_s;

  // one fetched word, read through five formats
  typedef union packed {
    r_fmt_s  r_fmt;
    i_fmt_s  i_fmt;
    s_fmt_s  s_fmt;
    uj_fmt_s u_fmt;
    uj_fmt_s j_fmt;
  } rv_inst_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic {
    OP_A_REG,
    OP_A_PC
  } op_a_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_PC4,
    WB_LOAD
  } wb_sel_e;

  typedef enum logic [1:0] {
    PC_SEQ,
    PC_JAL,
    PC_JALR
  } pc_sel_e;

  typedef enum logic {
    SIZE_WORD,
    SIZE_DOUBLE
  } mem_size_e;

  // decoded controls for one instruction
  typedef struct packed {
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] imm;
    alu_op_e             alu_op;
    op_a_sel_e           op_a_sel;
    logic                use_imm;
    wb_sel_e             wb_sel;
    pc_sel_e             pc_sel;
  } ctrl_s;

  // control to bus master
  typedef struct packed {
    logic                valid;
    logic                we;
    mem_size_e           size;
    logic                load_signed;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
  } bus_req_s;

  // bus master to core, rdata already aligned
  typedef struct packed {
    logic                done;
    logic [`RV_XLEN-1:0] rdata;
  } bus_rsp_s;

  // wishbone master outputs
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [7:0]          sel;
    logic [`RV_XLEN-1:0] adr;
    logic [`RV_XLEN-1:0] dat;
  } wb_m2s_s;

endpackage

`default_nettype wire

// ==== rtl/rv_consts.svh ====
// rv64 core constants
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path width
`define RV_XLEN 64
// first fetch address after reset
`define RV_RESET_PC 64'h0000_0000_0000_1000

// major opcodes
`define RV_OP_OP     7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_SYSTEM 7'b1110011

// funct3 values
`define RV_F3_ADD 3'b000
`define RV_F3_SLT 3'b010
`define RV_F3_XOR 3'b100
`define RV_F3_OR  3'b110
`define RV_F3_AND 3'b111
`define RV_F3_W   3'b010
`define RV_F3_D   3'b011

// funct7 values, plus the one fixed system word
`define RV_F7_BASE 7'b0000000
`define RV_F7_SUB  7'b0100000
`define RV_EBREAK  32'h0010_0073

`endif
